// File: logic/conv_pkg.sv
/*
 * Shared definitions for the convolution offload data path.
 * Holds the host bus widths, the context word layout, the read tags
 * and the lane-wise complex multiply used by the engine and the
 * testbench model. Referenced by scoped names only.
 */

package conv_pkg;

  // host bus widths
  localparam int ADDR_W  = 58;
  localparam int MDATA_W = 14;
  localparam int LINE_W  = 512;
  localparam int CTX_W   = 512;
  localparam int COUNT_W = 32;

  // lane layout of a cache line
  localparam int LANES  = 8;
  localparam int PART_W = 32;

  // byte address to cache-line address
  localparam int LINE_OFFSET_W = 6;

  typedef logic [ADDR_W-1:0]  line_addr_t;
  typedef logic [MDATA_W-1:0] mdata_t;
  typedef logic [LINE_W-1:0]  line_t;
  typedef logic [COUNT_W-1:0] count_t;

  // context word field offsets
  localparam int CTX_SRC_LSB     = 64;
  localparam int CTX_DEST_LSB    = 128;
  localparam int CTX_IMG_CNT_LSB = 192;
  localparam int CTX_FILTER_LSB  = 256;
  localparam int CTX_KER_CNT_LSB = 384;

  // metadata bit 0 tells image from kernel responses
  localparam logic TAG_IMAGE  = 1'b0;
  localparam logic TAG_KERNEL = 1'b1;

  // lane n: real at 64n, imaginary at 64n+32, all results mod 2^32
  function automatic line_t mult_line(input line_t a, input line_t b);
    line_t             p;
    logic [PART_W-1:0] ar;
    logic [PART_W-1:0] ai;
    logic [PART_W-1:0] br;
    logic [PART_W-1:0] bi;
    p = '0;
    for (int n = 0; n < LANES; n++) begin
      ar = a[2*PART_W*n +: PART_W];
      ai = a[2*PART_W*n + PART_W +: PART_W];
      br = b[2*PART_W*n +: PART_W];
      bi = b[2*PART_W*n + PART_W +: PART_W];
      p[2*PART_W*n +: PART_W]          = ar * br - ai * bi;
      p[2*PART_W*n + PART_W +: PART_W] = ar * bi + ai * br;
    end
    return p;
  endfunction

endpackage

// File: logic/rd_req_seq.sv
/*
 * Read request sequencer.
 * Captures the job fields on start, requests the image block and,
 * once the engine holds all image lines, the kernel stream. Requests
 * stop while the host is almost full; kernel reads also need a credit,
 * one per free result FIFO slot, returned on each write request.
 */

`timescale 1ns/1ps

module rd_req_seq #(
  parameter int IMG_DEPTH_BITS  = 4,
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic [conv_pkg::CTX_W-1:0] afu_context,
  input  logic                       rd_req_almostfull,
  input  logic                       img_ready,
  input  logic                       wr_req_en,
  output conv_pkg::line_addr_t       rd_req_addr,
  output conv_pkg::mdata_t           rd_req_mdata,
  output logic                       rd_req_en,
  output conv_pkg::line_addr_t       dest_addr,
  output conv_pkg::count_t           img_count,
  output conv_pkg::count_t           ker_count
);

  localparam conv_pkg::count_t IMG_MAX = conv_pkg::count_t'(2 ** IMG_DEPTH_BITS);
  localparam int CREDIT_W = FIFO_DEPTH_BITS + 1;
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(2 ** FIFO_DEPTH_BITS);

  typedef enum logic [2:0] {
    S_IDLE,
    S_IMAGE,
    S_WAIT_IMG,
    S_KERNEL,
    S_FINISH
  } state_t;

  state_t               state;
  conv_pkg::line_addr_t src_addr;
  conv_pkg::line_addr_t filter_addr;
  conv_pkg::count_t     req_idx;
  conv_pkg::count_t     ctx_img_count;
  logic [CREDIT_W-1:0]  credits;
  logic                 ker_issue;

  assign ctx_img_count = afu_context[conv_pkg::CTX_IMG_CNT_LSB +: conv_pkg::COUNT_W];
  assign ker_issue = (state == S_KERNEL) && !rd_req_almostfull && (credits != '0);

  // free result slots not yet claimed by a kernel read
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_MAX;
    end else begin
      case ({ker_issue, wr_req_en})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_IDLE;
      rd_req_en <= 1'b0;
    end else begin
      rd_req_en <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            src_addr    <= afu_context[conv_pkg::CTX_SRC_LSB + conv_pkg::LINE_OFFSET_W
                                       +: conv_pkg::ADDR_W];
            dest_addr   <= afu_context[conv_pkg::CTX_DEST_LSB + conv_pkg::LINE_OFFSET_W
                                       +: conv_pkg::ADDR_W];
            filter_addr <= afu_context[conv_pkg::CTX_FILTER_LSB + conv_pkg::LINE_OFFSET_W
                                       +: conv_pkg::ADDR_W];
            ker_count   <= afu_context[conv_pkg::CTX_KER_CNT_LSB +: conv_pkg::COUNT_W];
            // image store cannot hold more than its depth
            img_count   <= (ctx_img_count > IMG_MAX) ? IMG_MAX : ctx_img_count;
            req_idx     <= '0;
            state       <= S_IMAGE;
          end
        end

        S_IMAGE: begin
          if (!rd_req_almostfull) begin
            rd_req_en    <= 1'b1;
            rd_req_addr  <= src_addr + conv_pkg::line_addr_t'(req_idx);
            rd_req_mdata <= conv_pkg::mdata_t'(conv_pkg::TAG_IMAGE);
            if (req_idx == img_count - 1) begin
              req_idx <= '0;
              state   <= S_WAIT_IMG;
            end else begin
              req_idx <= req_idx + 1;
            end
          end
        end

        // kernel reads only once every image line is stored
        S_WAIT_IMG: begin
          if (img_ready) begin
            state <= (ker_count == '0) ? S_FINISH : S_KERNEL;
          end
        end

        S_KERNEL: begin
          if (ker_issue) begin
            rd_req_en    <= 1'b1;
            rd_req_addr  <= filter_addr + conv_pkg::line_addr_t'(req_idx);
            rd_req_mdata <= conv_pkg::mdata_t'(conv_pkg::TAG_KERNEL);
            req_idx      <= req_idx + 1;
            if (req_idx == ker_count - 1) begin
              state <= S_FINISH;
            end
          end
        end

        // all credits back means every result has been written
        S_FINISH: begin
          if (credits == CREDIT_MAX) begin
            state <= S_IDLE;
          end
        end

        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: logic/kernel_mult_engine.sv
/*
 * Response path and complex multiply engine.
 * Image responses fill a small line store; each kernel response is
 * paired with the image line at a read index that wraps at the image
 * count, then multiplied lane by lane. Two register stages give
 * mult_valid two cycles after the kernel response.
 */

`timescale 1ns/1ps

module kernel_mult_engine #(
  parameter int IMG_DEPTH_BITS = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic             rd_rsp_valid,
  input  conv_pkg::mdata_t rd_rsp_mdata,
  input  conv_pkg::line_t  rd_rsp_data,
  input  conv_pkg::count_t img_count,
  output logic             img_ready,
  output logic             mult_valid,
  output conv_pkg::line_t  mult_line
);

  localparam int IMG_LINES = 2 ** IMG_DEPTH_BITS;

  conv_pkg::line_t         img_mem [IMG_LINES];

  // one extra bit so a full store can match img_count
  logic [IMG_DEPTH_BITS:0] img_wr_idx;
  logic [IMG_DEPTH_BITS:0] img_rd_idx;

  logic                    img_rsp;
  logic                    ker_rsp;
  logic                    last_img;
  logic                    wrap_rd;

  // first stage: kernel line and its image partner
  logic                    ker_valid;
  conv_pkg::line_t         ker_reg;
  conv_pkg::line_t         img_reg;

  assign img_rsp  = rd_rsp_valid && (rd_rsp_mdata[0] == conv_pkg::TAG_IMAGE);
  assign ker_rsp  = rd_rsp_valid && (rd_rsp_mdata[0] == conv_pkg::TAG_KERNEL);
  assign last_img = (conv_pkg::count_t'(img_wr_idx) + 1 == img_count);
  assign wrap_rd  = (conv_pkg::count_t'(img_rd_idx) + 1 == img_count);

  always_ff @(posedge clk) begin
    if (img_rsp) begin
      img_mem[img_wr_idx[IMG_DEPTH_BITS-1:0]] <= rd_rsp_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      img_wr_idx <= '0;
      img_rd_idx <= '0;
      img_ready  <= 1'b0;
      ker_valid  <= 1'b0;
      mult_valid <= 1'b0;
    end else begin
      ker_valid  <= ker_rsp;
      mult_valid <= ker_valid;
      if (start) begin
        img_wr_idx <= '0;
        img_rd_idx <= '0;
        img_ready  <= 1'b0;
      end else begin
        if (img_rsp) begin
          img_wr_idx <= img_wr_idx + 1'b1;
          if (last_img) begin
            img_ready <= 1'b1;
          end
        end
        // kernel k pairs with image k mod img_count
        if (ker_rsp) begin
          img_rd_idx <= wrap_rd ? '0 : img_rd_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ker_rsp) begin
      ker_reg <= rd_rsp_data;
      img_reg <= img_mem[img_rd_idx[IMG_DEPTH_BITS-1:0]];
    end
    if (ker_valid) begin
      mult_line <= conv_pkg::mult_line(ker_reg, img_reg);
    end
  end

endmodule

// File: logic/out_fifo.sv
/*
 * Synchronous result FIFO of cache lines.
 * First-word fall-through: dout shows the head entry while empty is
 * low, and re pops it. There is no full flag; the kernel read credits
 * keep the writer from ever overrunning the buffer.
 */

`timescale 1ns/1ps

module out_fifo #(
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  logic            clk,
  input  logic            reset,
  input  conv_pkg::line_t din,
  input  logic            we,
  input  logic            re,
  output conv_pkg::line_t dout,
  output logic            empty
);

  localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

  conv_pkg::line_t          mem [DEPTH];

  // top bit is the wrap flag
  logic [FIFO_DEPTH_BITS:0] wr_ptr;
  logic [FIFO_DEPTH_BITS:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign dout  = mem[rd_ptr[FIFO_DEPTH_BITS-1:0]];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr[FIFO_DEPTH_BITS-1:0]] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // pop on an empty buffer is ignored
      if (re && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// File: logic/wr_req_gen.sv
/*
 * Write request generator.
 * Pops results while the host accepts writes and sends them to
 * consecutive destination lines, with the running line index in the
 * metadata. done rises after the last of ker_count writes and holds
 * until the next start.
 */

`timescale 1ns/1ps

module wr_req_gen (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 fifo_empty,
  input  conv_pkg::line_t      fifo_dout,
  input  logic                 wr_req_almostfull,
  input  conv_pkg::line_addr_t dest_addr,
  input  conv_pkg::count_t     ker_count,
  output logic                 fifo_re,
  output logic                 wr_req_en,
  output conv_pkg::line_addr_t wr_req_addr,
  output conv_pkg::mdata_t     wr_req_mdata,
  output conv_pkg::line_t      wr_req_data,
  output logic                 done
);

  // lines popped so far in this job
  conv_pkg::count_t wr_count;

  assign fifo_re = !fifo_empty && !wr_req_almostfull;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_req_en <= 1'b0;
      wr_count  <= '0;
      done      <= 1'b0;
    end else begin
      wr_req_en <= fifo_re;
      if (start) begin
        wr_count <= '0;
        done     <= 1'b0;
      end else begin
        if (fifo_re) begin
          wr_count <= wr_count + 1;
        end
        // last write went out on the previous edge
        if (wr_req_en && wr_count == ker_count) begin
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_re) begin
      wr_req_addr  <= dest_addr + conv_pkg::line_addr_t'(wr_count);
      wr_req_mdata <= conv_pkg::mdata_t'(wr_count);
      wr_req_data  <= fifo_dout;
    end
  end

endmodule

// File: logic/conv_afu.sv
/*
 * Top level of the convolution offload accelerator.
 * A start pulse loads a job from the context word; image lines are
 * fetched and stored, each kernel line is multiplied with its image
 * line and the results are written back to the destination region.
 * done marks the end of the job. Instantiate with the host ports.
 */

`timescale 1ns/1ps

module conv_afu #(
  parameter int IMG_DEPTH_BITS  = 4,
  parameter int FIFO_DEPTH_BITS = 3
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic [conv_pkg::CTX_W-1:0]   afu_context,
  output conv_pkg::line_addr_t         rd_req_addr,
  output conv_pkg::mdata_t             rd_req_mdata,
  output logic                         rd_req_en,
  input  logic                         rd_req_almostfull,
  input  logic                         rd_rsp_valid,
  input  conv_pkg::mdata_t             rd_rsp_mdata,
  input  conv_pkg::line_t              rd_rsp_data,
  output conv_pkg::line_addr_t         wr_req_addr,
  output conv_pkg::mdata_t             wr_req_mdata,
  output conv_pkg::line_t              wr_req_data,
  output logic                         wr_req_en,
  input  logic                         wr_req_almostfull,
  output logic                         done
);

  // job fields from the sequencer
  conv_pkg::line_addr_t dest_addr;
  conv_pkg::count_t     img_count;
  conv_pkg::count_t     ker_count;

  logic                 img_ready;
  logic                 mult_valid;
  conv_pkg::line_t      mult_line;

  // result buffer to writer
  logic                 fifo_re;
  logic                 fifo_empty;
  conv_pkg::line_t      fifo_dout;

  rd_req_seq #(
    .IMG_DEPTH_BITS  (IMG_DEPTH_BITS),
    .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
  ) rd_req_seq_inst (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .afu_context       (afu_context),
    .rd_req_almostfull (rd_req_almostfull),
    .img_ready         (img_ready),
    .wr_req_en         (wr_req_en),
    .rd_req_addr       (rd_req_addr),
    .rd_req_mdata      (rd_req_mdata),
    .rd_req_en         (rd_req_en),
    .dest_addr         (dest_addr),
    .img_count         (img_count),
    .ker_count         (ker_count)
  );

  kernel_mult_engine #(
    .IMG_DEPTH_BITS (IMG_DEPTH_BITS)
  ) kernel_mult_engine_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_mdata (rd_rsp_mdata),
    .rd_rsp_data  (rd_rsp_data),
    .img_count    (img_count),
    .img_ready    (img_ready),
    .mult_valid   (mult_valid),
    .mult_line    (mult_line)
  );

  out_fifo #(
    .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
  ) out_fifo_inst (
    .clk   (clk),
    .reset (reset),
    .din   (mult_line),
    .we    (mult_valid),
    .re    (fifo_re),
    .dout  (fifo_dout),
    .empty (fifo_empty)
  );

  wr_req_gen wr_req_gen_inst (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .fifo_empty        (fifo_empty),
    .fifo_dout         (fifo_dout),
    .wr_req_almostfull (wr_req_almostfull),
    .dest_addr         (dest_addr),
    .ker_count         (ker_count),
    .fifo_re           (fifo_re),
    .wr_req_en         (wr_req_en),
    .wr_req_addr       (wr_req_addr),
    .wr_req_mdata      (wr_req_mdata),
    .wr_req_data       (wr_req_data),
    .done              (done)
  );

endmodule

// File: tb/conv_afu_props.sv
/*
 * Handshake and reset properties for the accelerator top level,
 * bound into conv_afu. failures counts the violated properties.
 */

`timescale 1ns/1ps

module conv_afu_props (
  input logic clk,
  input logic reset,
  input logic rd_req_almostfull,
  input logic rd_req_en,
  input logic wr_req_almostfull,
  input logic wr_req_en,
  input logic done
);

  int failures = 0;

  // a sampled almost-full blocks the next read request
  assert property (@(posedge clk) disable iff (reset) rd_req_almostfull |=> !rd_req_en)
    else begin
      $error("read request issued after rd_req_almostfull");
      failures++;
    end

  assert property (@(posedge clk) disable iff (reset) wr_req_almostfull |=> !wr_req_en)
    else begin
      $error("write request issued after wr_req_almostfull");
      failures++;
    end

  // reset clears requests and done
  assert property (@(posedge clk) reset |=> (!rd_req_en && !done))
    else begin
      $error("rd_req_en or done high after a reset cycle");
      failures++;
    end

endmodule

bind conv_afu conv_afu_props conv_afu_props_inst (
  .clk               (clk),
  .reset             (reset),
  .rd_req_almostfull (rd_req_almostfull),
  .rd_req_en         (rd_req_en),
  .wr_req_almostfull (wr_req_almostfull),
  .wr_req_en         (wr_req_en),
  .done              (done)
);

// File: tb/conv_afu_tb.sv
/*
 * Testbench for the convolution offload accelerator.
 * Runs three random jobs against a host memory model with random
 * response delay and almost-full traffic, and checks every read and
 * write request and the result data against a reference model.
 */

`timescale 1ns/1ps

module conv_afu_tb;

  localparam int IMG_DEPTH_BITS  = 4;
  localparam int FIFO_DEPTH_BITS = 3;
  localparam int NUM_JOBS        = 3;
  localparam int MAX_IMG         = 2 ** IMG_DEPTH_BITS;
  localparam int MAX_KER         = 64;
  localparam int WATCHDOG_CYCLES = NUM_JOBS * (MAX_IMG + MAX_KER) * 40 + 2000;

  logic clk, reset, start, rd_req_en, rd_req_almostfull, rd_rsp_valid;
  logic wr_req_en, wr_req_almostfull, done;
  logic [conv_pkg::CTX_W-1:0] afu_context;
  conv_pkg::line_addr_t rd_req_addr, wr_req_addr;
  conv_pkg::mdata_t     rd_req_mdata, rd_rsp_mdata, wr_req_mdata;
  conv_pkg::line_t      rd_rsp_data, wr_req_data;

  integer seed = 32'hddd0;
  integer host_seed = 32'hddd0 ^ 32'h5a5a;
  int value_errors = 0, proto_errors = 0, cycle = 0, af_hold = 0;
  int job_img_cnt, job_ker_cnt, wr_seen;
  bit long_af = 0, done_seen = 0;
  conv_pkg::line_addr_t job_src, job_dest, job_filter;

  // expected reads and pending host responses
  conv_pkg::line_addr_t exp_rd_addr[$], rsp_addr[$];
  conv_pkg::mdata_t     exp_rd_tag[$], rsp_tag[$];
  int                   rsp_due[$];

  conv_afu #(.IMG_DEPTH_BITS(IMG_DEPTH_BITS), .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) conv_afu_inst (
    .clk(clk), .reset(reset), .start(start), .afu_context(afu_context),
    .rd_req_addr(rd_req_addr), .rd_req_mdata(rd_req_mdata), .rd_req_en(rd_req_en),
    .rd_req_almostfull(rd_req_almostfull), .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_mdata(rd_rsp_mdata), .rd_rsp_data(rd_rsp_data), .wr_req_addr(wr_req_addr),
    .wr_req_mdata(wr_req_mdata), .wr_req_data(wr_req_data), .wr_req_en(wr_req_en),
    .wr_req_almostfull(wr_req_almostfull), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // host memory content, seeded from the whole line address
  function automatic conv_pkg::line_t line_for_addr(input conv_pkg::line_addr_t a);
    conv_pkg::line_t l;
    integer s;
    s = a[31:0] ^ {a[57:32], 6'h15} ^ 32'h3c96e1a7;
    for (int i = 0; i < 2 * conv_pkg::LANES; i++) begin
      l[32*i +: 32] = $random(s);
    end
    // odd lines carry extreme lane 0 values
    if (a[0]) begin
      l[31:0]  = 32'hffffffff;
      l[63:32] = 32'h80000000;
    end
    return l;
  endfunction

  function automatic conv_pkg::line_t expected_result(input int k);
    conv_pkg::line_t ker;
    conv_pkg::line_t img;
    ker = line_for_addr(job_filter + conv_pkg::line_addr_t'(k));
    img = line_for_addr(job_src + conv_pkg::line_addr_t'(k % job_img_cnt));
    return conv_pkg::mult_line(ker, img);
  endfunction

  task automatic check_addr(input string name, input conv_pkg::line_addr_t exp,
                            input conv_pkg::line_addr_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_mdata(input string name, input conv_pkg::mdata_t exp,
                             input conv_pkg::mdata_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_line(input string name, input conv_pkg::line_t exp,
                            input conv_pkg::line_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic protocol_error(input string what);
    $display("protocol error at cycle %0d: %s", cycle, what);
    proto_errors++;
  endtask

  // request monitor, host memory responses and almost-full traffic
  always @(negedge clk) begin
    cycle++;
    if (!reset) begin
      if (rd_req_en) begin
        if (rd_req_almostfull) protocol_error("read request after rd_req_almostfull");
        if (exp_rd_addr.size() == 0) begin
          protocol_error("unexpected read request");
        end else begin
          check_addr("rd_req_addr", exp_rd_addr.pop_front(), rd_req_addr);
          check_mdata("rd_req_mdata", exp_rd_tag.pop_front(), rd_req_mdata);
        end
        rsp_addr.push_back(rd_req_addr);
        rsp_tag.push_back(rd_req_mdata);
        rsp_due.push_back(cycle + 1 + $unsigned($random(host_seed)) % 6);
      end
      if (wr_req_en) begin
        if (wr_req_almostfull) protocol_error("write request after wr_req_almostfull");
        if (wr_seen >= job_ker_cnt) begin
          protocol_error("write request beyond the kernel count");
        end else begin
          check_addr("wr_req_addr", job_dest + conv_pkg::line_addr_t'(wr_seen), wr_req_addr);
          check_mdata("wr_req_mdata", conv_pkg::mdata_t'(wr_seen), wr_req_mdata);
          check_line("wr_req_data", expected_result(wr_seen), wr_req_data);
        end
        wr_seen++;
      end
      if (done && !done_seen) begin
        done_seen = 1;
        if (wr_seen != job_ker_cnt) protocol_error("done rose before all writes");
      end
    end
    rd_rsp_valid = 1'b0;
    if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
      void'(rsp_due.pop_front());
      rd_rsp_valid = 1'b1;
      rd_rsp_mdata = rsp_tag.pop_front();
      rd_rsp_data  = line_for_addr(rsp_addr.pop_front());
    end
    if (af_hold > 0) begin
      af_hold--;
    end else if (long_af) begin
      wr_req_almostfull = !wr_req_almostfull;
      af_hold = 8 + $unsigned($random(host_seed)) % 24;
    end else begin
      wr_req_almostfull = ($random(host_seed) & 3) == 0;
    end
    rd_req_almostfull = ($random(host_seed) & 3) == 0;
  end

  task automatic run_job(input int img_cnt, input int ker_cnt, input bit long_stall);
    logic [conv_pkg::CTX_W-1:0] ctx;
    job_src     = conv_pkg::line_addr_t'({$random(seed), $random(seed)});
    job_dest    = conv_pkg::line_addr_t'({$random(seed), $random(seed)});
    job_filter  = conv_pkg::line_addr_t'({$random(seed), $random(seed)});
    job_img_cnt = img_cnt;
    job_ker_cnt = ker_cnt;
    wr_seen     = 0;
    long_af     = long_stall;
    for (int i = 0; i < img_cnt; i++) begin
      exp_rd_addr.push_back(job_src + conv_pkg::line_addr_t'(i));
      exp_rd_tag.push_back(conv_pkg::mdata_t'(conv_pkg::TAG_IMAGE));
    end
    for (int k = 0; k < ker_cnt; k++) begin
      exp_rd_addr.push_back(job_filter + conv_pkg::line_addr_t'(k));
      exp_rd_tag.push_back(conv_pkg::mdata_t'(conv_pkg::TAG_KERNEL));
    end
    ctx = '0;
    ctx[conv_pkg::CTX_SRC_LSB +: 64]     = {job_src, 6'b0};
    ctx[conv_pkg::CTX_DEST_LSB +: 64]    = {job_dest, 6'b0};
    ctx[conv_pkg::CTX_FILTER_LSB +: 64]  = {job_filter, 6'b0};
    ctx[conv_pkg::CTX_IMG_CNT_LSB +: 32] = img_cnt;
    ctx[conv_pkg::CTX_KER_CNT_LSB +: 32] = ker_cnt;
    @(negedge clk);
    afu_context = ctx;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    done_seen = 0;
    if (done) protocol_error("done still high after start");
    while (!done_seen) @(negedge clk);
    if (exp_rd_addr.size() != 0) protocol_error("read requests missing at done");
    // done holds until the next start
    repeat (5) begin
      @(negedge clk);
      if (!done) protocol_error("done dropped before the next start");
    end
  endtask

  initial begin
    reset = 1'b1;
    start = 1'b0;
    afu_context = '0;
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_mdata = '0;
    rd_rsp_data = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    if (rd_req_en || wr_req_en || done) protocol_error("outputs not cleared by reset");
    run_job(1 + $unsigned($random(seed)) % MAX_IMG, 1 + $unsigned($random(seed)) % 40, 0);
    run_job(1 + $unsigned($random(seed)) % MAX_IMG, 1 + $unsigned($random(seed)) % 40, 0);
    // long write stalls with many more kernel lines than FIFO slots
    run_job(1 + $unsigned($random(seed)) % MAX_IMG, MAX_KER, 1);
    $display("errors: %0d value mismatches, %0d protocol errors, %0d assertion failures",
             value_errors, proto_errors, conv_afu_inst.conv_afu_props_inst.failures);
    if (value_errors == 0 && proto_errors == 0 &&
        conv_afu_inst.conv_afu_props_inst.failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles before all jobs finished", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
logic/conv_pkg.sv
logic/rd_req_seq.sv
logic/kernel_mult_engine.sv
logic/out_fifo.sv
logic/wr_req_gen.sv
logic/conv_afu.sv
tb/conv_afu_props.sv
tb/conv_afu_tb.sv
